/* Makefile */
TOP = decodeStageTb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module decodeStage

clean:
	rm -rf obj_dir $(LOG)

/* dv/decodeRef.svh */
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// expected control word, straight from the instruction table
function automatic ctrlWord_t refCtrl(input logic [31:0] w);
    ctrlWord_t  c;
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       legal;
    op    = w[6:0];
    f3    = w[14:12];
    f7    = w[31:25];
    c     = '0;
    c.aluASrc = A_RS1;
    legal = 1'b1;
    case (op)
        7'b0010011: begin // addi sltiu
            c.immFmt = FMT_I;
            if (f3 == 3'b011) begin
                c.aluCtrl = ALU_SLTU;
            end else if (f3 != 3'b000) begin
                legal = 1'b0;
            end
        end
        7'b0110011: begin // add sub
            c.immFmt  = FMT_R;
            c.aluBSrc = B_RS2;
            if (f3 != 3'b000 || !(f7 inside {7'h00, 7'h20})) begin
                legal = 1'b0;
            end else if (f7 == 7'h20) begin
                c.aluCtrl = ALU_SUB;
            end
        end
        7'b0110111: begin // lui
            c.immFmt  = FMT_U;
            c.aluCtrl = ALU_PASSB;
            c.aluASrc = A_PC;
        end
        7'b0010111: begin // auipc
            c.immFmt  = FMT_U;
            c.aluASrc = A_PC;
        end
        7'b1101111: begin // jal, rd gets pc+4
            c.immFmt  = FMT_J;
            c.aluASrc = A_PC;
            c.aluBSrc = B_FOUR;
            c.branch  = BR_JAL;
        end
        7'b1100111: begin // jalr
            c.immFmt  = FMT_I;
            c.aluASrc = A_PC;
            c.aluBSrc = B_FOUR;
            c.branch  = BR_JALR;
            legal     = (f3 == 3'b000);
        end
        7'b0000011: begin // ld
            c.immFmt   = FMT_I;
            c.memOp    = MEM_D;
            c.memToReg = 1'b1;
            legal      = (f3 == 3'b011);
        end
        7'b0100011: begin // sd
            c.immFmt = FMT_S;
            c.memOp  = MEM_D;
            c.memWr  = 1'b1;
            legal    = (f3 == 3'b011);
        end
        7'b1100011: begin // beq bne
            c.immFmt  = FMT_B;
            c.aluCtrl = ALU_SUB;
            c.aluBSrc = B_RS2;
            if (f3 == 3'b000) begin
                c.branch = BR_EQ;
            end else if (f3 == 3'b001) begin
                c.branch = BR_NE;
            end else begin
                legal = 1'b0;
            end
        end
        default: legal = 1'b0;
    endcase
    if (!legal) begin
        c         = '0; // pc, imm operand, no branch, no memory, no format
        c.aluCtrl = ALU_PASSB;
        c.illegal = 1'b1;
    end
    c.regWr = !c.illegal && (c.immFmt inside {FMT_R, FMT_I, FMT_U, FMT_J});
    return c;
endfunction

// expected immediate, sign taken from the signed field value
function automatic logic [`XLEN-1:0] refImm(input logic [31:0] w, input immFmt_t fmt);
    logic signed [`XLEN-1:0] v;
    case (fmt)
        FMT_I:   v = $signed(w[31:20]);
        FMT_S:   v = $signed({w[31:25], w[11:7]});
        FMT_B:   v = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
        FMT_U:   v = $signed({w[31:12], 12'h000});
        FMT_J:   v = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
        default: v = '0;
    endcase
    return v;
endfunction

function automatic decoded_t refBundle(input logic [`XLEN-1:0] pc, input logic [31:0] w);
    decoded_t b;
    b.ctrl = refCtrl(w);
    b.imm  = refImm(w, b.ctrl.immFmt);
    b.pc   = pc;
    b.rd   = w[11:7]; // raw fields, whatever the format
    b.rs1  = w[19:15];
    b.rs2  = w[24:20];
    return b;
endfunction

`endif

/* dv/decodeStageTb.sv */
`include "decode_defs.svh"

module decodeStageTb
    import isaPkg::*, ctrlPkg::*;
();

    logic        clk;
    logic        rstN;
    logic        inValid;
    logic        inReady;
    fetchEntry_t inEntry;
    logic        outValid;
    logic        outReady;
    decoded_t    outBundle;

    integer      seed = 32986;
    integer      readySeed = 32986; // own stream for the ready pattern
    int          readyMode = 1; // 0 random, 1 always, 2 never
    int          accepted;
    int          ctrlErrs = 0;
    int          immErrs = 0;
    int          entryErrs = 0;
    int          flowErrs = 0;
    int          timeouts = 0;
    decoded_t    expQ[$];
    logic [31:0] wordQ[$];

    // opcodes outside the supported set
    logic [6:0]  unusedOps [8] = '{7'h00, 7'h7f, 7'h0f, 7'h73, 7'h1b, 7'h3b, 7'h53, 7'h2f};
    // opcodes whose func3 is checked
    logic [6:0]  f3Ops [8] = '{7'h13, 7'h03, 7'h23, 7'h63, 7'h67, 7'h33, 7'h13, 7'h63};

    `include "decodeRef.svh"

    decodeStage dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic finishRun();
        $display("errors ctrl=%0d imm=%0d entry=%0d flow=%0d timeout=%0d",
                 ctrlErrs, immErrs, entryErrs, flowErrs, timeouts);
        if (ctrlErrs + immErrs + entryErrs + flowErrs + timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic giveUp(input string what);
        $display("timeout at %0t: no progress while %s", $time, what);
        timeouts++;
        finishRun();
    endtask

    task automatic checkCtrl(input ctrlWord_t got, input ctrlWord_t exp, input logic [31:0] w);
        if (got !== exp) begin
            ctrlErrs++;
            $display("ERR %0t: ctrl for word %h is %h, expected %h", $time, w, got, exp);
        end
    endtask

    task automatic checkImm(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                            input logic [31:0] w);
        if (got !== exp) begin
            immErrs++;
            $display("ERR %0t: imm for word %h is %h, expected %h", $time, w, got, exp);
        end
    endtask

    task automatic checkEntry(input decoded_t got, input decoded_t exp);
        if (got.pc !== exp.pc || got.rd !== exp.rd || got.rs1 !== exp.rs1
                || got.rs2 !== exp.rs2) begin
            entryErrs++;
            $display("ERR %0t: pc/rd/rs1/rs2 %h %0d %0d %0d, expected %h %0d %0d %0d",
                     $time, got.pc, got.rd, got.rs1, got.rs2,
                     exp.pc, exp.rd, exp.rs1, exp.rs2);
        end
    endtask

    task automatic checkFlow(input string what, input int got, input int exp);
        if (got != exp) begin
            flowErrs++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // random word of one class, 0..11 supported, 12..14 illegal
    function automatic logic [31:0] makeWord(input int cls);
        logic [31:0] w;
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [6:0]  f7;
        w  = $random(seed);
        f3 = w[14:12];
        f7 = w[31:25];
        case (cls)
            0:  {op, f3} = {7'b0010011, 3'b000};
            1:  {op, f3} = {7'b0010011, 3'b011};
            2:  {op, f3, f7} = {7'b0110011, 3'b000, 7'b0000000};
            3:  {op, f3, f7} = {7'b0110011, 3'b000, 7'b0100000};
            4:  op = 7'b0110111;
            5:  op = 7'b0010111;
            6:  op = 7'b1101111;
            7:  {op, f3} = {7'b1100111, 3'b000};
            8:  {op, f3} = {7'b0000011, 3'b011};
            9:  {op, f3} = {7'b0100011, 3'b011};
            10: {op, f3} = {7'b1100011, 3'b000};
            11: {op, f3} = {7'b1100011, 3'b001};
            12: op = unusedOps[w[2:0]];
            13: begin
                op = f3Ops[w[2:0]];
                f3 = {1'b1, f3[1:0]}; // every supported func3 is below 4
            end
            default: begin
                {op, f3} = {7'b0110011, 3'b000};
                f7 = {f7[6:1], 1'b1}; // neither add nor sub
            end
        endcase
        return {f7, w[24:15], f3, w[11:7], op};
    endfunction

    task automatic driveEntry(input logic [31:0] w);
        logic [`XLEN-1:0] pc;
        pc      = {$random(seed), $random(seed)};
        pc[1:0] = 2'b00;
        inValid = 1'b1;
        inEntry = {pc, w};
        expQ.push_back(refBundle(pc, w));
        wordQ.push_back(w);
    endtask

    // held until inReady, transfer at the next rising edge
    task automatic sendWord(input logic [31:0] w);
        int n;
        @(negedge clk);
        driveEntry(w);
        n = 0;
        while (!inReady) begin
            @(negedge clk);
            n++;
            if (n > 100) giveUp("an instruction waited for inReady");
        end
    endtask

    task automatic idleCycles(input int k);
        repeat (k) begin
            @(negedge clk);
            inValid = 1'b0;
        end
    endtask

    task automatic waitDrained(input string what);
        int n;
        n = 0;
        while (expQ.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > 200) giveUp(what);
        end
    endtask

    // scoreboard, outputs are flops so the falling edge sees them settled
    initial begin
        decoded_t    expB;
        logic [31:0] w;
        outReady = 1'b0;
        forever begin
            @(negedge clk);
            case (readyMode)
                0:       outReady = ($random(readySeed) & 3) != 0;
                1:       outReady = 1'b1;
                default: outReady = 1'b0;
            endcase
            if (outValid && outReady) begin
                if (expQ.size() == 0) begin
                    flowErrs++;
                    $display("ERR %0t: output bundle with nothing expected", $time);
                end else begin
                    expB = expQ.pop_front();
                    w    = wordQ.pop_front();
                    checkCtrl(outBundle.ctrl, expB.ctrl, w);
                    checkImm(outBundle.imm, expB.imm, w);
                    checkEntry(outBundle, expB);
                end
            end
        end
    end

    initial begin
        int   i;
        int   n;
        logic full;
        inValid = 1'b0;
        inEntry = '0;
        rstN    = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkFlow("outValid after reset", int'(outValid), 0);
        checkFlow("inReady after reset", int'(inReady), 1);

        for (i = 0; i < 15; i++) begin
            sendWord(makeWord(i));
        end
        sendWord(32'hfff00093); // addi x1, x0, -1
        sendWord(32'h800000b7); // lui, sign bit set
        sendWord(32'h8000006f); // jal, most negative offset
        sendWord(32'hfe209ce3); // bne backwards
        idleCycles(1);
        waitDrained("draining the directed words");

        @(posedge clk);
        readyMode = 0;
        for (i = 0; i < 400; i++) begin
            idleCycles($unsigned($random(seed)) % 3);
            sendWord(makeWord($unsigned($random(seed)) % 15));
        end
        idleCycles(1);
        @(posedge clk);
        readyMode = 1;
        waitDrained("draining the random traffic");

        // stall the output and fill the queue
        @(posedge clk);
        readyMode = 2;
        accepted  = 0;
        full      = 1'b0;
        n         = 0;
        while (!full) begin
            @(negedge clk);
            if (inReady) begin
                driveEntry(makeWord($unsigned($random(seed)) % 12));
                accepted++;
            end else begin
                inValid = 1'b0;
                full    = 1'b1;
            end
            n++;
            if (n > 50) giveUp("filling the input queue");
        end
        checkFlow("inputs accepted before inReady fell", accepted, `QUEUE_DEPTH + 1);
        repeat (3) begin
            @(negedge clk);
            checkFlow("inReady while stalled", int'(inReady), 0);
            checkFlow("outValid while stalled", int'(outValid), 1);
        end
        @(posedge clk);
        readyMode = 1;
        waitDrained("draining after back-pressure");
        idleCycles(2);
        finishRun();
    end

endmodule

/* files.f */
+incdir+hdl
+incdir+dv
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/instrQueue.sv
hdl/controlGen.sv
hdl/immGen.sv
hdl/decodeOutReg.sv
hdl/decodeStage.sv
dv/decodeStageTb.sv

/* hdl/controlGen.sv */
module controlGen import isaPkg::*, ctrlPkg::*; (
    input  instrWord_u instr,
    output ctrlWord_t  ctrl
);

    immFmt_t fmtByOp;
    logic    illegal;

    // format depends on opcode alone
    always_comb begin
        case (instr.r.opcode)
            OP_IMM:    fmtByOp = FMT_I;
            OP_LOAD:   fmtByOp = FMT_I;
            OP_JALR:   fmtByOp = FMT_I;
            OP_REG:    fmtByOp = FMT_R;
            OP_LUI:    fmtByOp = FMT_U;
            OP_AUIPC:  fmtByOp = FMT_U;
            OP_JAL:    fmtByOp = FMT_J;
            OP_STORE:  fmtByOp = FMT_S;
            OP_BRANCH: fmtByOp = FMT_B;
            default:   fmtByOp = FMT_NONE;
        endcase
    end

    always_comb begin
        ctrl          = '0;
        ctrl.aluCtrl  = ALU_ADD; // common case rs1 + imm
        ctrl.aluASrc  = A_RS1;
        ctrl.aluBSrc  = B_IMM;
        ctrl.branch   = BR_NONE;
        ctrl.memWr    = 1'b0;
        ctrl.memOp    = MEM_NONE;
        ctrl.memToReg = 1'b0;
        illegal       = 1'b0;

        casez ({instr.r.func7, instr.r.func3, instr.r.opcode})
            {7'b???????, F3_ADD, OP_IMM}: begin // addi
            end
            {7'b???????, F3_SLTIU, OP_IMM}: begin
                ctrl.aluCtrl = ALU_SLTU;
            end
            {7'b???????, 3'b???, OP_AUIPC}: begin
                ctrl.aluASrc = A_PC;
            end
            {7'b???????, 3'b???, OP_LUI}: begin
                ctrl.aluCtrl = ALU_PASSB; // imm passes to rd
                ctrl.aluASrc = A_PC;
            end
            {7'b???????, 3'b???, OP_JAL}: begin
                ctrl.aluASrc = A_PC;
                ctrl.aluBSrc = B_FOUR;
                ctrl.branch  = BR_JAL;
            end
            {7'b???????, F3_ADD, OP_JALR}: begin
                ctrl.aluASrc = A_PC;
                ctrl.aluBSrc = B_FOUR;
                ctrl.branch  = BR_JALR;
            end
            {7'b???????, F3_DWORD, OP_STORE}: begin // sd
                ctrl.memWr = 1'b1;
                ctrl.memOp = MEM_D;
            end
            {7'b???????, F3_DWORD, OP_LOAD}: begin // ld
                ctrl.memOp    = MEM_D;
                ctrl.memToReg = 1'b1;
            end
            {F7_ADD, F3_ADD, OP_REG}: begin
                ctrl.aluBSrc = B_RS2;
            end
            {F7_SUB, F3_ADD, OP_REG}: begin
                ctrl.aluCtrl = ALU_SUB;
                ctrl.aluBSrc = B_RS2;
            end
            {7'b???????, F3_BEQ, OP_BRANCH}: begin
                ctrl.aluCtrl = ALU_SUB; // compare by subtraction
                ctrl.aluBSrc = B_RS2;
                ctrl.branch  = BR_EQ;
            end
            {7'b???????, F3_BNE, OP_BRANCH}: begin
                ctrl.aluCtrl = ALU_SUB;
                ctrl.aluBSrc = B_RS2;
                ctrl.branch  = BR_NE;
            end
            default: begin
                ctrl.aluCtrl = ALU_PASSB;
                ctrl.aluASrc = A_PC;
                illegal      = 1'b1;
            end
        endcase

        ctrl.illegal = illegal;
        ctrl.immFmt  = illegal ? FMT_NONE : fmtByOp;
        ctrl.regWr   = !illegal && (fmtByOp inside {FMT_R, FMT_I, FMT_U, FMT_J});
    end

endmodule

/* hdl/ctrlPkg.sv */
`include "decode_defs.svh"

package ctrlPkg;

    import isaPkg::*;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'b0000,
        ALU_PASSB = 4'b0001, // operand b straight through
        ALU_SUB   = 4'b1000,
        ALU_SLTU  = 4'b1010
    } aluCtrl_t;

    typedef enum logic {
        A_PC  = 1'b0,
        A_RS1 = 1'b1
    } aluASrc_t;

    typedef enum logic [1:0] {
        B_IMM  = 2'd0,
        B_RS2  = 2'd1,
        B_FOUR = 2'd2 // link address pc+4
    } aluBSrc_t;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_JAL  = 3'd1,
        BR_JALR = 3'd2,
        BR_EQ   = 3'd4,
        BR_NE   = 3'd5
    } branch_t;

    typedef enum logic [2:0] {
        MEM_NONE = 3'd0,
        MEM_D    = 3'd1 // doubleword access
    } memOp_t;

    typedef struct packed {
        aluCtrl_t aluCtrl;
        aluASrc_t aluASrc;
        aluBSrc_t aluBSrc;
        branch_t  branch;
        logic     memWr;
        memOp_t   memOp;
        logic     memToReg;
        logic     regWr;
        immFmt_t  immFmt;
        logic     illegal;
    } ctrlWord_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        instrWord_u       instr;
    } fetchEntry_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] imm;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        ctrlWord_t        ctrl;
    } decoded_t;

endpackage

/* hdl/decodeOutReg.sv */
module decodeOutReg import ctrlPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     inValid,
    input  decoded_t inBundle,
    output logic     pop,
    output logic     outValid,
    input  logic     outReady,
    output decoded_t outBundle
);

    logic     full;
    decoded_t bundleQ;

    // take a new bundle when empty or when the current one leaves
    assign pop       = inValid && (!full || outReady);
    assign outValid  = full;
    assign outBundle = bundleQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            full <= 1'b0;
        end else if (pop) begin
            full <= 1'b1;
        end else if (outReady) begin
            full <= 1'b0; // drained, nothing behind it
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            bundleQ <= inBundle;
        end
    end

    // stalled bundle must not change or vanish
    holdWhileStalled: assert property (
        @(posedge clk) disable iff (!rstN)
        (outValid && !outReady) |=> (outValid && $stable(outBundle))
    ) else $error("decodeOutReg: bundle changed under back-pressure");

endmodule

/* hdl/decodeStage.sv */
`include "decode_defs.svh"

module decodeStage import ctrlPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        inValid,
    output logic        inReady,
    input  fetchEntry_t inEntry,
    output logic        outValid,
    input  logic        outReady,
    output decoded_t    outBundle
);

    logic             headValid;
    fetchEntry_t      headEntry;
    logic             headPop;
    ctrlWord_t        ctrlW;
    logic [`XLEN-1:0] immW;
    decoded_t         headBundle;

    instrQueue queue0 (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inReady   (inReady),
        .inEntry   (inEntry),
        .headValid (headValid),
        .headEntry (headEntry),
        .headPop   (headPop)
    );

    controlGen ctrlGen0 (
        .instr (headEntry.instr),
        .ctrl  (ctrlW)
    );

    immGen immGen0 (
        .instr  (headEntry.instr),
        .immFmt (ctrlW.immFmt),
        .imm    (immW)
    );

    // register fields taken raw from the word
    assign headBundle = '{
        pc:   headEntry.pc,
        imm:  immW,
        rd:   headEntry.instr.r.rd,
        rs1:  headEntry.instr.r.rs1,
        rs2:  headEntry.instr.r.rs2,
        ctrl: ctrlW
    };

    decodeOutReg outReg0 (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (headValid),
        .inBundle  (headBundle),
        .pop       (headPop),
        .outValid  (outValid),
        .outReady  (outReady),
        .outBundle (outBundle)
    );

endmodule

/* hdl/decode_defs.svh */
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// data path and pc width
`define XLEN 64

// input queue entries, power of two only
`define QUEUE_DEPTH 4

`endif

/* hdl/immGen.sv */
`include "decode_defs.svh"

module immGen import isaPkg::*; (
    input  instrWord_u       instr,
    input  immFmt_t          immFmt,
    output logic [`XLEN-1:0] imm
);

    logic signBit;

    assign signBit = instr.r.func7[6]; // instr[31] in every format

    always_comb begin
        case (immFmt)
            FMT_I: imm = {{(`XLEN-12){signBit}}, instr.i.imm12};
            FMT_S: imm = {{(`XLEN-12){signBit}}, instr.s.immHi, instr.s.immLo};
            FMT_B: begin
                imm = {{(`XLEN-13){signBit}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10to5, instr.b.imm4to1, 1'b0}; // halfword aligned
            end
            FMT_U: imm = {{(`XLEN-32){signBit}}, instr.u.imm20, 12'b0};
            FMT_J: begin
                imm = {{(`XLEN-21){signBit}}, instr.j.imm20, instr.j.imm19to12,
                       instr.j.imm11, instr.j.imm10to1, 1'b0};
            end
            default: imm = '0; // R and NONE carry no immediate
        endcase
    end

endmodule

/* hdl/instrQueue.sv */
`include "decode_defs.svh"

module instrQueue import ctrlPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        inValid,
    output logic        inReady,
    input  fetchEntry_t inEntry,
    output logic        headValid,
    output fetchEntry_t headEntry,
    input  logic        headPop
);

    localparam int PtrW = $clog2(`QUEUE_DEPTH);
    localparam int CntW = PtrW + 1;

    fetchEntry_t         mem [`QUEUE_DEPTH];
    logic [PtrW-1:0]     wrPtr;
    logic [PtrW-1:0]     rdPtr;
    logic [CntW-1:0]     count;
    logic                push;
    logic                pop;

    assign inReady   = (count != CntW'(`QUEUE_DEPTH));
    assign headValid = (count != '0);
    assign headEntry = mem[rdPtr]; // head read straight from storage

    assign push = inValid && inReady;
    assign pop  = headPop && headValid;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= inEntry;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1; // wraps as depth is a power of two
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle or push and pop together
            endcase
        end
    end

    // the output slot must only retire an entry that exists
    noPopWhenEmpty: assert property (
        @(posedge clk) disable iff (!rstN)
        headPop |-> headValid
    ) else $error("instrQueue: pop while empty");

endmodule

/* hdl/isaPkg.sv */
package isaPkg;

    localparam logic [6:0] OP_IMM    = 7'b0010011; // addi sltiu
    localparam logic [6:0] OP_REG    = 7'b0110011; // add sub
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011; // ld
    localparam logic [6:0] OP_STORE  = 7'b0100011; // sd
    localparam logic [6:0] OP_BRANCH = 7'b1100011; // beq bne

    localparam logic [2:0] F3_ADD    = 3'b000; // addi add sub jalr
    localparam logic [2:0] F3_SLTIU  = 3'b011;
    localparam logic [2:0] F3_DWORD  = 3'b011; // ld sd
    localparam logic [2:0] F3_BEQ    = 3'b000;
    localparam logic [2:0] F3_BNE    = 3'b001;
    localparam logic [6:0] F7_ADD    = 7'b0000000;
    localparam logic [6:0] F7_SUB    = 7'b0100000;

    typedef enum logic [2:0] {
        FMT_NONE = 3'd0,
        FMT_R    = 3'd1,
        FMT_I    = 3'd2,
        FMT_S    = 3'd3,
        FMT_B    = 3'd4,
        FMT_U    = 3'd5,
        FMT_J    = 3'd6
    } immFmt_t;

    typedef struct packed {
        logic [6:0] func7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rView_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  func3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iView_t;

    typedef struct packed {
        logic [6:0] immHi; // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] immLo; // imm[4:0]
        logic [6:0] opcode;
    } sView_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bView_t;

    typedef struct packed {
        logic [19:0] imm20; // imm[31:12]
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uView_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jView_t;

    // one 32-bit word, read per format
    typedef union packed {
        rView_t r;
        iView_t i;
        sView_t s;
        bView_t b;
        uView_t u;
        jView_t j;
    } instrWord_u;

endpackage
